// ==== source/lsq_cfg_pkg.sv ====
`default_nettype none

// sizing of the load/store queue and its fields
package lsq_cfg_pkg;

    // number of queue slots
    localparam int n_entries = 8;

    // field widths of one memory operation
    localparam int tag_width = 4;
    localparam int addr_width = 16;
    localparam int data_width = 32;

    // slot index width, and the enqueue counter which needs one more bit for full
    localparam int ptr_width = $clog2(n_entries);
    localparam int ctr_width = ptr_width + 1;

endpackage

`default_nettype wire

// ==== source/lsq_entry_pkg.sv ====
`default_nettype none

// types that describe a queued memory operation and the issue stage
package lsq_entry_pkg;

    import lsq_cfg_pkg::*;

    // kind of memory operation
    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_e;

    // one queue slot, 54 bits
    // addr_ready is set once the address resolution for the tag came in
    typedef struct packed {
        mem_op_e                op;
        logic [tag_width-1:0]   tag;
        logic                   addr_ready;
        logic [addr_width-1:0]  addr;
        logic [data_width-1:0]  data;
    } lsq_entry_t;

    // output register of the issue stage
    typedef enum logic {
        st_empty = 1'b0,
        st_hold  = 1'b1
    } issue_state_e;

endpackage

`default_nettype wire

// ==== source/lsq_fill_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// dispatch side of the queue: enqueue handshake plus in-place slot writes
interface lsq_fill_if
    import lsq_cfg_pkg::*;
    import lsq_entry_pkg::*;
();

    // enqueue handshake
    logic                          enq_valid;
    logic                          enq_ready;
    lsq_entry_t                    enq_entry;

    // per-slot writes, wr_entry[i] is taken where wr_en[i] is high
    logic [n_entries-1:0]          wr_en;
    lsq_entry_t [n_entries-1:0]    wr_entry;

    // current queue contents, so the producer can match tags
    lsq_entry_t [n_entries-1:0]    entries;
    logic [n_entries-1:0]          live;

    modport producer (
        output enq_valid,
        input  enq_ready,
        output enq_entry,
        output wr_en,
        output wr_entry,
        input  entries,
        input  live
    );

    modport queue (
        input  enq_valid,
        output enq_ready,
        input  enq_entry,
        input  wr_en,
        input  wr_entry,
        output entries,
        output live
    );

endinterface

`default_nettype wire

// ==== source/lsq_drain_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// issue side of the queue: snapshot of all slots and a select-based dequeue
interface lsq_drain_if
    import lsq_cfg_pkg::*;
    import lsq_entry_pkg::*;
();

    // snapshot of the queue, slot 0 is the oldest
    lsq_entry_t [n_entries-1:0]    entries;
    logic [n_entries-1:0]          live;

    // dequeue, deq_sel is one-hot or all zero
    logic [n_entries-1:0]          deq_sel;
    logic                          deq_ready;

    // valid is the OR of deq_sel, entry is the selected slot
    logic                          deq_valid;
    lsq_entry_t                    deq_entry;

    modport queue (
        output entries,
        output live,
        input  deq_sel,
        input  deq_ready,
        output deq_valid,
        output deq_entry
    );

    modport consumer (
        input  entries,
        input  live,
        output deq_sel,
        output deq_ready,
        input  deq_valid,
        input  deq_entry
    );

endinterface

`default_nettype wire

// ==== source/lsq_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_dispatch
    import lsq_cfg_pkg::*;
    import lsq_entry_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  mem_op_e                 in_op,
    input  logic [tag_width-1:0]    in_tag,
    input  logic [data_width-1:0]   in_data,
    input  logic                    res_valid,
    input  logic [tag_width-1:0]    res_tag,
    input  logic [addr_width-1:0]   res_addr,
    lsq_fill_if.producer            fill
);

    // enqueue handshake goes straight through
    assign fill.enq_valid = in_valid;
    assign in_ready = fill.enq_ready;

    // new entry, address still unknown
    always_comb begin
        fill.enq_entry.op = in_op;
        fill.enq_entry.tag = in_tag;
        fill.enq_entry.addr_ready = 1'b0;
        fill.enq_entry.addr = '0;
        fill.enq_entry.data = in_data;
    end

    // tag match against live slots only, stale slots above the counter hold junk
    // a resolution without a live match is simply dropped
    always_comb begin
        for (int i = 0; i < n_entries; i++) begin
            fill.wr_en[i] = res_valid & fill.live[i] & (fill.entries[i].tag == res_tag);
            // copy of the slot with the address filled in
            fill.wr_entry[i] = fill.entries[i];
            fill.wr_entry[i].addr_ready = 1'b1;
            fill.wr_entry[i].addr = res_addr;
        end
    end

endmodule

`default_nettype wire

// ==== source/lsq_shift_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_shift_queue
    import lsq_cfg_pkg::*;
    import lsq_entry_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    lsq_fill_if.queue       fill,
    lsq_drain_if.queue      drain
);

    // slot 0 holds the oldest operation
    lsq_entry_t [n_entries-1:0]    q_r;
    lsq_entry_t [n_entries-1:0]    q_next;

    // number of live slots, top bit set means full
    logic [ctr_width-1:0]          ctr_r;
    logic [ctr_width-1:0]          ctr_next;

    logic                          full;
    logic                          enq;
    logic                          deq;
    logic                          shift_run;
    logic [n_entries-1:0]          shift;
    logic [n_entries-1:0]          live;
    lsq_entry_t                    deq_mux;

    // each slot after enqueue and in-place write, before any shift
    // index n_entries is the slot just past a full queue
    lsq_entry_t [n_entries:0]      upd;

    assign full = ctr_r[ptr_width];
    assign enq = fill.enq_valid & fill.enq_ready;
    assign deq = drain.deq_valid & drain.deq_ready;

    // room when not full, or when a slot frees up this cycle
    assign fill.enq_ready = ~full | deq;
    assign drain.deq_valid = |drain.deq_sel;

    // every slot at or above the selected one takes the slot behind it
    always_comb begin
        shift_run = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            shift_run = shift_run | drain.deq_sel[i];
            shift[i] = shift_run & deq;
        end
    end

    // enqueue goes to the counter slot, writes go to their own slot
    always_comb begin
        for (int j = 0; j < n_entries; j++) begin
            if (enq && (ctr_r == ctr_width'(j))) begin
                upd[j] = fill.enq_entry;
            end else if (fill.wr_en[j]) begin
                upd[j] = fill.wr_entry[j];
            end else begin
                upd[j] = q_r[j];
            end
        end
        // enqueue into a full queue only happens together with a dequeue
        upd[n_entries] = (enq && full) ? fill.enq_entry : '0;
    end

    // a shifting slot pulls the updated slot behind it
    // so enqueue lands one lower and writes follow their entry
    always_comb begin
        for (int i = 0; i < n_entries; i++) begin
            q_next[i] = shift[i] ? upd[i+1] : upd[i];
        end
    end

    assign ctr_next = ctr_r + ctr_width'(enq) - ctr_width'(deq);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctr_r <= '0;
        end else begin
            ctr_r <= ctr_next;
        end
    end

    always_ff @(posedge clk) begin
        q_r <= q_next;
    end

    // occupancy mask from the counter
    always_comb begin
        for (int i = 0; i < n_entries; i++) begin
            live[i] = (ctr_width'(i) < ctr_r);
        end
    end

    // AND-OR mux over the one-hot select
    always_comb begin
        deq_mux = '0;
        for (int i = 0; i < n_entries; i++) begin
            if (drain.deq_sel[i]) begin
                deq_mux = deq_mux | q_r[i];
            end
        end
    end

    assign drain.deq_entry = deq_mux;

    // both sides see the same snapshot
    assign drain.entries = q_r;
    assign drain.live = live;
    assign fill.entries = q_r;
    assign fill.live = live;

endmodule

`default_nettype wire

// ==== source/lsq_issue_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_issue_select
    import lsq_cfg_pkg::*;
    import lsq_entry_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    lsq_drain_if.consumer           drain,
    output logic                    out_valid,
    input  logic                    out_ready,
    output mem_op_e                 out_op,
    output logic [tag_width-1:0]    out_tag,
    output logic [addr_width-1:0]   out_addr,
    output logic [data_width-1:0]   out_data
);

    issue_state_e           state_r;
    lsq_entry_t             out_r;
    logic [n_entries-1:0]   elig;
    logic [n_entries-1:0]   sel;
    logic                   store_seen;
    logic                   found;
    logic                   take;

    // age-order scan, slot 0 first
    always_comb begin
        store_seen = 1'b0;
        found = 1'b0;
        elig = '0;
        sel = '0;
        for (int i = 0; i < n_entries; i++) begin
            if (drain.live[i] && drain.entries[i].addr_ready) begin
                if (drain.entries[i].op == op_load) begin
                    // a load may only pass older loads
                    elig[i] = ~store_seen;
                end else begin
                    // store goes out only as the oldest entry
                    elig[i] = (i == 0);
                end
            end
            // lowest eligible slot wins
            if (elig[i] && !found) begin
                sel[i] = 1'b1;
                found = 1'b1;
            end
            // any live store blocks all younger loads
            if (drain.live[i] && (drain.entries[i].op == op_store)) begin
                store_seen = 1'b1;
            end
        end
    end

    // output register free now, or freed at this edge
    assign take = (state_r == st_empty) | out_ready;

    // select does not look at ready, the queue qualifies it
    assign drain.deq_sel = sel;
    assign drain.deq_ready = take;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_r <= st_empty;
        end else if (take) begin
            state_r <= drain.deq_valid ? st_hold : st_empty;
        end
    end

    // captured in the same edge as the dequeue
    always_ff @(posedge clk) begin
        if (take && drain.deq_valid) begin
            out_r <= drain.deq_entry;
        end
    end

    assign out_valid = (state_r == st_hold);
    assign out_op = out_r.op;
    assign out_tag = out_r.tag;
    assign out_addr = out_r.addr;
    assign out_data = out_r.data;

endmodule

`default_nettype wire

// ==== source/lsq_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_subsystem
    import lsq_cfg_pkg::*;
    import lsq_entry_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // dispatch
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic                    in_op,
    input  logic [tag_width-1:0]    in_tag,
    input  logic [data_width-1:0]   in_data,

    // address resolution by tag
    input  logic                    res_valid,
    input  logic [tag_width-1:0]    res_tag,
    input  logic [addr_width-1:0]   res_addr,

    // issued operation
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic                    out_op,
    output logic [tag_width-1:0]    out_tag,
    output logic [addr_width-1:0]   out_addr,
    output logic [data_width-1:0]   out_data
);

    mem_op_e in_op_e;
    mem_op_e out_op_e;

    // op bit to and from the enum used inside
    assign in_op_e = mem_op_e'(in_op);
    assign out_op = out_op_e;

    lsq_fill_if fill_if_i ();
    lsq_drain_if drain_if_i ();

    lsq_dispatch dispatch_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op_e),
        .in_tag     (in_tag),
        .in_data    (in_data),
        .res_valid  (res_valid),
        .res_tag    (res_tag),
        .res_addr   (res_addr),
        .fill       (fill_if_i.producer)
    );

    lsq_shift_queue queue_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill       (fill_if_i.queue),
        .drain      (drain_if_i.queue)
    );

    lsq_issue_select issue_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .drain      (drain_if_i.consumer),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_op     (out_op_e),
        .out_tag    (out_tag),
        .out_addr   (out_addr),
        .out_data   (out_data)
    );

endmodule

`default_nettype wire

// ==== tb/lsq_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_subsystem_tb
    import lsq_cfg_pkg::*;
    import lsq_entry_pkg::*;
();

    // one table row: dispatch, resolution and output back-pressure
    typedef struct packed {
        logic                   in_valid;
        mem_op_e                in_op;
        logic [tag_width-1:0]   in_tag;
        logic [data_width-1:0]  in_data;
        logic                   res_valid;
        logic [tag_width-1:0]   res_tag;
        logic [addr_width-1:0]  res_addr;
        logic                   out_ready;
    } stim_row_t;

    logic clk, rst_n, in_valid, in_ready, in_op, res_valid, out_valid, out_ready, out_op;
    logic [tag_width-1:0] in_tag, res_tag, out_tag;
    logic [data_width-1:0] in_data, out_data;
    logic [addr_width-1:0] res_addr, out_addr;

    stim_row_t rows[$];
    lsq_entry_t model_q[$];
    lsq_entry_t expected_q[$];
    lsq_entry_t held_entry;
    logic model_hold, held_prev, table_ready;
    logic [31:0] rng_state;
    logic [tag_width-1:0] next_tag;
    int n_checks, n_errors;

    lsq_subsystem dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_bit(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %t: %s is %b, expected %b", $realtime, what, got, exp);
        end
    endtask

    task automatic check_entry(input lsq_entry_t got, input lsq_entry_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %t: %s op=%0d tag=%0d addr=%h data=%h, expected %0d %0d %h %h",
                     $realtime, what, got.op, got.tag, got.addr, got.data,
                     exp.op, exp.tag, exp.addr, exp.data);
        end
    endtask

    task automatic add_row(input logic iv, input mem_op_e op, input logic [tag_width-1:0] tag,
                           input logic rv, input logic [tag_width-1:0] rtag, input logic ordy);
        stim_row_t r;
        logic [31:0] a;
        r.in_valid = iv;
        r.in_op = op;
        r.in_tag = tag;
        r.in_data = next_rand();
        r.res_valid = rv;
        r.res_tag = rtag;
        a = next_rand();
        r.res_addr = a[addr_width-1:0];
        r.out_ready = ordy;
        rows.push_back(r);
    endtask

    task automatic dispatch_row(input mem_op_e op, input logic [tag_width-1:0] tag,
                                input logic ordy);
        add_row(1'b1, op, tag, 1'b0, '0, ordy);
    endtask

    task automatic resolve_row(input logic [tag_width-1:0] tag, input logic ordy);
        add_row(1'b0, op_load, '0, 1'b1, tag, ordy);
    endtask

    task automatic idle_rows(input int n, input logic ordy);
        for (int k = 0; k < n; k++) begin
            add_row(1'b0, op_load, '0, 1'b0, '0, ordy);
        end
    endtask

    // a few fresh operations, resolved in shuffled order, then drained
    task automatic random_group();
        logic [tag_width-1:0] tags[4];
        logic [tag_width-1:0] t;
        logic [31:0] r;
        int size;
        int j;
        r = next_rand();
        size = 1 + int'(r % 4);
        for (int k = 0; k < size; k++) begin
            r = next_rand();
            tags[k] = next_tag;
            next_tag = next_tag + 1'b1;
            dispatch_row(r[0] ? op_store : op_load, tags[k], r[2:1] != 2'b00);
        end
        for (int k = size - 1; k > 0; k--) begin
            r = next_rand();
            j = int'(r % (k + 1));
            t = tags[k];
            tags[k] = tags[j];
            tags[j] = t;
        end
        for (int k = 0; k < size; k++) begin
            r = next_rand();
            resolve_row(tags[k], r[1:0] != 2'b00);
            if (r[4:3] == 2'b00) begin
                idle_rows(1 + int'(r[6:5]), r[7]);
            end
        end
        idle_rows(12, 1'b1);
    endtask

    // lowest eligible slot by the ordering rule, -1 when none
    function automatic int pick_slot();
        logic store_seen;
        store_seen = 1'b0;
        for (int i = 0; i < model_q.size(); i++) begin
            if (model_q[i].addr_ready) begin
                if (model_q[i].op == op_load && !store_seen) return i;
                if (model_q[i].op == op_store && i == 0) return i;
            end
            if (model_q[i].op == op_store) store_seen = 1'b1;
        end
        return -1;
    endfunction

    // checks outputs before the coming edge, then moves the model past it
    task automatic step_model(input stim_row_t row);
        lsq_entry_t got;
        lsq_entry_t e;
        logic take;
        logic exp_ready;
        int slot;
        take = !model_hold || row.out_ready;
        slot = take ? pick_slot() : -1;
        exp_ready = (model_q.size() < n_entries) || (slot >= 0);
        check_bit(in_ready, exp_ready, "in_ready");
        check_bit(out_valid, model_hold, "out_valid");
        got.op = mem_op_e'(out_op);
        got.tag = out_tag;
        got.addr_ready = 1'b1;
        got.addr = out_addr;
        got.data = out_data;
        // held output must not move while out_ready is low
        if (held_prev && out_valid) check_entry(got, held_entry, "held output");
        if (out_valid && row.out_ready) begin
            if (expected_q.size() == 0) begin
                n_errors++;
                $display("output handshake at %t with no operation expected", $realtime);
            end else begin
                check_entry(got, expected_q.pop_front(), "issued entry");
            end
        end
        held_prev = out_valid && !row.out_ready;
        held_entry = got;
        if (take) begin
            model_hold = (slot >= 0);
            if (slot >= 0) expected_q.push_back(model_q[slot]);
        end
        // resolution only reaches entries already live
        if (row.res_valid) begin
            for (int i = 0; i < model_q.size(); i++) begin
                e = model_q[i];
                if (e.tag == row.res_tag) begin
                    e.addr = row.res_addr;
                    e.addr_ready = 1'b1;
                    model_q[i] = e;
                end
            end
        end
        if (slot >= 0) model_q.delete(slot);
        if (row.in_valid && exp_ready) begin
            e.op = row.in_op;
            e.tag = row.in_tag;
            e.addr_ready = 1'b0;
            e.addr = '0;
            e.data = row.in_data;
            model_q.push_back(e);
        end
    endtask

    initial begin
        wait (table_ready === 1'b1);
        repeat (rows.size() * 20) @(posedge clk);
        $display("watchdog timeout, run did not end within %0d cycles", rows.size() * 20);
        $display("Test failed");
        $finish;
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        {rst_n, in_valid, in_op, in_tag, in_data, res_valid, res_tag, res_addr} = '0;
        out_ready = 1'b0;
        {model_hold, held_prev, table_ready} = '0;
        n_checks = 0;
        n_errors = 0;
        rng_state = 32'hdbd26f86;
        // younger loads pass an unresolved older load
        for (int k = 1; k <= 3; k++) dispatch_row(op_load, k, 1'b1);
        resolve_row(3, 1'b1);
        resolve_row(1, 1'b1);
        resolve_row(2, 1'b1);
        idle_rows(8, 1'b1);
        // store blocks younger loads and waits to be oldest
        dispatch_row(op_load, 4, 1'b1);
        dispatch_row(op_store, 5, 1'b1);
        dispatch_row(op_load, 6, 1'b1);
        dispatch_row(op_load, 7, 1'b1);
        resolve_row(6, 1'b1);
        resolve_row(7, 1'b1);
        resolve_row(5, 1'b1);
        idle_rows(3, 1'b1);
        resolve_row(4, 1'b1);
        idle_rows(10, 1'b1);
        // fill to full, one refused dispatch, then dispatch beside an issue
        for (int k = 8; k < 16; k++) dispatch_row(op_load, k, 1'b1);
        dispatch_row(op_load, 0, 1'b1);
        idle_rows(2, 1'b1);
        resolve_row(8, 1'b1);
        dispatch_row(op_load, 0, 1'b1);
        for (int k = 9; k < 17; k++) resolve_row(k[tag_width-1:0], 1'b1);
        idle_rows(10, 1'b1);
        // held output, resolution of tag 4 while it shifts down
        for (int k = 1; k <= 4; k++) dispatch_row(op_load, k, 1'b0);
        resolve_row(1, 1'b0);
        idle_rows(2, 1'b0);
        resolve_row(3, 1'b0);
        idle_rows(2, 1'b0);
        resolve_row(4, 1'b1);
        idle_rows(2, 1'b0);
        resolve_row(2, 1'b0);
        idle_rows(12, 1'b1);
        // resolutions for tags that are not live
        dispatch_row(op_store, 5, 1'b1);
        resolve_row(12, 1'b1);
        idle_rows(4, 1'b1);
        dispatch_row(op_load, 6, 1'b1);
        resolve_row(13, 1'b1);
        resolve_row(5, 1'b1);
        resolve_row(6, 1'b1);
        idle_rows(10, 1'b1);
        // resolution beside the dispatch of its own tag finds no live entry
        add_row(1'b1, op_load, 7, 1'b1, 7, 1'b1);
        idle_rows(3, 1'b1);
        resolve_row(7, 1'b1);
        idle_rows(4, 1'b1);
        next_tag = '0;
        for (int g = 0; g < 8; g++) random_group();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_bit(in_ready, 1'b1, "in_ready after reset");
        check_bit(out_valid, 1'b0, "out_valid after reset");
        for (int r = 0; r < rows.size(); r++) begin
            @(negedge clk);
            {in_valid, in_op, in_tag, in_data} = {rows[r].in_valid, rows[r].in_op,
                                                  rows[r].in_tag, rows[r].in_data};
            {res_valid, res_tag, res_addr} = {rows[r].res_valid, rows[r].res_tag,
                                              rows[r].res_addr};
            out_ready = rows[r].out_ready;
            #1;
            step_model(rows[r]);
        end
        if (model_q.size() != 0 || expected_q.size() != 0) begin
            n_errors++;
            $display("%0d operations still queued and %0d unissued at the end",
                     model_q.size(), expected_q.size());
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== lsq_subsystem.f ====
source/lsq_cfg_pkg.sv
source/lsq_entry_pkg.sv
source/lsq_fill_if.sv
source/lsq_drain_if.sv
source/lsq_dispatch.sv
source/lsq_shift_queue.sv
source/lsq_issue_select.sv
source/lsq_subsystem.sv
tb/lsq_subsystem_tb.sv
